// ==== bench/bus_checker.sv ====
module bus_checker (
  input logic                       clk,
  input logic                       rst,
  input logic                       arvalid_i,
  input logic                       arready_i,
  input logic [bus_pkg::ADDR_W-1:0] araddr_i,
  input bus_pkg::axi_size_t         arsize_i,
  input logic                       awvalid_i,
  input logic                       awready_i,
  input logic [bus_pkg::ADDR_W-1:0] awaddr_i,
  input bus_pkg::axi_size_t         awsize_i,
  input logic                       wvalid_i,
  input logic                       wready_i,
  input logic [63:0]                wdata_i,
  input logic [7:0]                 wstrb_i,
  input logic                       ifu_rvalid_i,
  input logic                       lsu_rvalid_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int fails = 0; // read by the testbench

  ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i) && $stable(arsize_i))
  else
  begin
    $error("AR valid or payload changed before arready");
    fails++;
  end

  aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i) && $stable(awsize_i))
  else
  begin
    $error("AW valid or payload changed before awready");
    fails++;
  end

  w_hold: assert property (@(posedge clk) disable iff (rst)
    wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wstrb_i))
  else
  begin
    $error("W valid or payload changed before wready");
    fails++;
  end

  one_owner: assert property (@(posedge clk) disable iff (rst)
    !(ifu_rvalid_i && lsu_rvalid_i))
  else
  begin
    $error("fetch and load data returned in the same cycle");
    fails++;
  end

  // state is settled after the first reset edge
  quiet_in_reset: assert property (@(negedge clk)
    rst |-> !(arvalid_i || awvalid_i || wvalid_i))
  else
  begin
    $error("master valid high during reset");
    fails++;
  end

endmodule

// ==== bench/bus_tb.sv ====
module bus_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import bus_pkg::*;

  localparam logic [ADDR_W-1:0] CLINT_BASE = 32'h0200_bff8;
  localparam logic [31:0] SEED = 32'h2b53_be56;
  localparam int N_TXN = 300;
  localparam int WATCHDOG_NS = 2 * N_TXN * 40 * 4;
  localparam int K_FETCH = 0;
  localparam int K_LOAD = 1;
  localparam int K_TIMER = 2;
  localparam int K_STORE = 3;

  logic              clk = 1'b0;
  logic              rst = 1'b1;
  logic [ADDR_W-1:0] ifu_araddr_i = '0;
  logic              ifu_arvalid_i = 1'b0;
  logic [DATA_W-1:0] ifu_rdata_o;
  logic              ifu_rvalid_o;
  logic [ADDR_W-1:0] lsu_araddr_i = '0;
  logic              lsu_arvalid_i = 1'b0;
  logic [7:0]        lsu_rstrb_i = 8'h0f;
  logic [DATA_W-1:0] lsu_rdata_o;
  logic              lsu_rvalid_o;
  logic [ADDR_W-1:0] lsu_awaddr_i = '0;
  logic              lsu_awvalid_i = 1'b0;
  logic [DATA_W-1:0] lsu_wdata_i = '0;
  logic [7:0]        lsu_wstrb_i = 8'h0f;
  logic              lsu_wready_o;
  logic [ADDR_W-1:0] m_araddr_o;
  axi_size_t         m_arsize_o;
  logic              m_arvalid_o;
  logic              m_arready_i = 1'b0;
  logic [63:0]       m_rdata_i = 64'd0;
  logic              m_rvalid_i = 1'b0;
  logic [ADDR_W-1:0] m_awaddr_o;
  axi_size_t         m_awsize_o;
  logic              m_awvalid_o;
  logic              m_awready_i = 1'b0;
  logic [63:0]       m_wdata_o;
  logic [7:0]        m_wstrb_o;
  logic              m_wvalid_o;
  logic              m_wready_i = 1'b0;
  logic              m_bvalid_i = 1'b0;

  axi_size_t   cur_size = SIZE_W; // size of the pending lsu request
  axi_size_t   exp_size;
  logic [31:0] ss = SEED ^ 32'h0f0f_f0f0;
  logic [31:0] r_addr = '0;
  int          ar_cnt = -1;
  int          aw_cnt = -1;
  int          w_cnt = -1;
  int          r_cnt = 0;
  int          b_cnt = 0;
  logic        aw_acc = 1'b0;
  logic        w_acc = 1'b0;
  logic        idle = 1'b1;
  int          kind = K_FETCH;
  int          age = 0;
  int          ar_hs = 0;
  int          aw_hs = 0;
  int          w_hs = 0;
  int          off;
  logic [63:0] edges = 64'd0; // model of mtime
  logic [31:0] exp_addr = '0;
  logic [31:0] timer_exp = '0;
  logic [31:0] sh;
  logic [3:0]  s4;
  logic [71:0] beat;
  logic [71:0] beat_q[$];
  int          val_errs = 0;
  int          other_errs = 0;
  int          total;

  bus_top #(
    .CLINT_BASE (CLINT_BASE)
  ) dut_i (.*);

  bind bus_top bus_checker chk_i (
    .clk          (clk),
    .rst          (rst),
    .arvalid_i    (m_arvalid_o),
    .arready_i    (m_arready_i),
    .araddr_i     (m_araddr_o),
    .arsize_i     (m_arsize_o),
    .awvalid_i    (m_awvalid_o),
    .awready_i    (m_awready_i),
    .awaddr_i     (m_awaddr_o),
    .awsize_i     (m_awsize_o),
    .wvalid_i     (m_wvalid_o),
    .wready_i     (m_wready_i),
    .wdata_i      (m_wdata_o),
    .wstrb_i      (m_wstrb_o),
    .ifu_rvalid_i (ifu_rvalid_o),
    .lsu_rvalid_i (lsu_rvalid_o)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // memory contents are a hash of the word address
  function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
    return xorshift({a[31:2], 2'b00} ^ 32'h6d2b_79f5);
  endfunction

  task automatic flag_error(input string msg);
    other_errs++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  task automatic check_rdata(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
    if (act !== exp)
    begin
      val_errs++;
      $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
                            input logic [ADDR_W-1:0] act);
    if (act !== exp)
    begin
      val_errs++;
      $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_wbeat(input logic [63:0] exp_data, input logic [7:0] exp_strb,
                             input logic [63:0] act_data, input logic [7:0] act_strb);
    if (act_data !== exp_data || act_strb !== exp_strb)
    begin
      val_errs++;
      $display("CHECK FAILED at %0t ns: m_wdata_o/m_wstrb_o expected %h/%h got %h/%h",
               $time, exp_data, exp_strb, act_data, act_strb);
    end
  endtask

  task automatic check_size(input string name, input axi_size_t exp, input axi_size_t act);
    if (act !== exp)
    begin
      val_errs++;
      $display("CHECK FAILED at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic run_fetch();
    logic [31:0] s;
    s = SEED;
    repeat (N_TXN)
    begin
      s = xorshift(s);
      repeat (s[1:0]) @(negedge clk);
      ifu_araddr_i  = {4'h8, s[27:2], 2'b00};
      ifu_arvalid_i = 1'b1;
      do @(posedge clk); while (!ifu_rvalid_o);
      @(negedge clk);
      ifu_arvalid_i = 1'b0;
    end
  endtask

  task automatic run_lsu();
    logic [31:0] s;
    logic [31:0] s2;
    logic [31:0] a;
    logic [7:0]  strb;
    s = SEED ^ 32'h1357_9bdf;
    repeat (N_TXN)
    begin
      s  = xorshift(s);
      s2 = xorshift(s);
      repeat (s[1:0]) @(negedge clk);
      case (s[5:4])
        2'd0:
        begin
          cur_size = SIZE_B;
          strb     = 8'h01;
        end
        2'd1:
        begin
          cur_size = SIZE_H;
          strb     = 8'h03;
        end
        default:
        begin
          cur_size = SIZE_W;
          strb     = 8'h0f;
        end
      endcase
      a = {4'h8, s2[27:0]};
      if (cur_size == SIZE_H)
        a[0] = 1'b0;
      if (cur_size == SIZE_W)
        a[1:0] = 2'b00;
      if (s[8:6] < 3'd3)
      begin
        lsu_awaddr_i  = a;
        lsu_wdata_i   = {s[15:0], s2[31:16]};
        lsu_wstrb_i   = strb;
        lsu_awvalid_i = 1'b1;
        do @(posedge clk); while (!lsu_wready_o);
        @(negedge clk);
        lsu_awvalid_i = 1'b0;
      end
      else
      begin
        if (s[8:6] == 3'd6) // one of the two mtime words
        begin
          a        = s2[0] ? CLINT_BASE + 32'd4 : CLINT_BASE;
          cur_size = SIZE_W;
          strb     = 8'h0f;
        end
        lsu_araddr_i  = a;
        lsu_rstrb_i   = strb;
        lsu_arvalid_i = 1'b1;
        do @(posedge clk); while (!lsu_rvalid_o);
        @(negedge clk);
        lsu_arvalid_i = 1'b0;
      end
    end
  endtask

  // slave gives ready after 0..3 cycles and a response 1..4 cycles after the handshake
  always @(negedge clk)
  begin
    m_arready_i = 1'b0;
    m_awready_i = 1'b0;
    m_wready_i  = 1'b0;
    m_rvalid_i  = 1'b0;
    m_bvalid_i  = 1'b0;
    if (rst)
    begin
      ar_cnt = -1;
      aw_cnt = -1;
      w_cnt  = -1;
      r_cnt  = 0;
      b_cnt  = 0;
      aw_acc = 1'b0;
      w_acc  = 1'b0;
    end
    else
    begin
      ss = xorshift(ss);
      if (r_cnt > 0)
      begin
        r_cnt--;
        if (r_cnt == 0)
        begin
          m_rvalid_i = 1'b1;
          m_rdata_i  = {mem_word({r_addr[31:3], 3'b100}), mem_word({r_addr[31:3], 3'b000})};
        end
      end
      if (b_cnt > 0)
      begin
        b_cnt--;
        m_bvalid_i = (b_cnt == 0);
      end
      if (m_arvalid_o)
      begin
        if (ar_cnt < 0)
          ar_cnt = int'(ss[1:0]);
        if (ar_cnt == 0)
        begin
          m_arready_i = 1'b1;
          r_addr      = m_araddr_o;
          r_cnt       = 1 + int'(ss[9:8]);
        end
        ar_cnt--;
      end
      if (m_awvalid_o)
      begin
        if (aw_cnt < 0)
          aw_cnt = int'(ss[3:2]);
        if (aw_cnt == 0)
        begin
          m_awready_i = 1'b1;
          aw_acc      = 1'b1;
        end
        aw_cnt--;
      end
      if (m_wvalid_o)
      begin
        if (w_cnt < 0)
          w_cnt = int'(ss[5:4]);
        if (w_cnt == 0)
        begin
          m_wready_i = 1'b1;
          w_acc      = 1'b1;
        end
        w_cnt--;
      end
      if (aw_acc && w_acc)
      begin
        b_cnt  = 1 + int'(ss[11:10]);
        aw_acc = 1'b0;
        w_acc  = 1'b0;
      end
    end
  end

  // monitor and scoreboard sample the values before each edge
  always @(posedge clk)
  begin
    if (rst)
    begin
      idle  = 1'b1;
      edges = 64'd0;
    end
    else
    begin
      if (edges == 64'd0 && (m_arvalid_o || m_awvalid_o || m_wvalid_o ||
                             ifu_rvalid_o || lsu_rvalid_o || lsu_wready_o))
        flag_error("master valid or completion output high after reset");
      if (idle)
      begin
        if (m_arvalid_o || m_awvalid_o || m_wvalid_o ||
            ifu_rvalid_o || lsu_rvalid_o || lsu_wready_o)
          flag_error("bus activity or completion output with no request granted");
        age   = 0;
        ar_hs = 0;
        aw_hs = 0;
        w_hs  = 0;
        if (lsu_awvalid_i)
        begin
          kind     = K_STORE;
          idle     = 1'b0;
          exp_addr = lsu_awaddr_i;
          exp_size = cur_size;
          off      = int'(lsu_awaddr_i[1:0]);
          sh       = lsu_wdata_i << (8 * off);
          s4       = lsu_wstrb_i[3:0] << off;
          beat_q.push_back({sh, sh, lsu_awaddr_i[2] ? {s4, 4'h0} : {4'h0, s4}});
        end
        else if (lsu_arvalid_i)
        begin
          idle      = 1'b0;
          exp_addr  = lsu_araddr_i;
          exp_size  = cur_size;
          kind      = K_LOAD;
          timer_exp = (lsu_araddr_i == CLINT_BASE + 32'd4) ? edges[63:32] : edges[31:0];
          if (lsu_araddr_i == CLINT_BASE || lsu_araddr_i == CLINT_BASE + 32'd4)
            kind = K_TIMER;
        end
        else if (ifu_arvalid_i)
        begin
          kind     = K_FETCH;
          idle     = 1'b0;
          exp_addr = ifu_araddr_i;
          exp_size = SIZE_W;
        end
      end
      else
      begin
        if (m_arvalid_o && m_arready_i)
        begin
          ar_hs++;
          if (kind != K_FETCH && kind != K_LOAD)
            flag_error("AR handshake outside a bus read");
          check_addr("m_araddr_o", exp_addr, m_araddr_o); // priority shows here
          check_size("m_arsize_o", exp_size, m_arsize_o);
        end
        if (m_awvalid_o && m_awready_i)
        begin
          aw_hs++;
          check_addr("m_awaddr_o", exp_addr, m_awaddr_o);
          check_size("m_awsize_o", exp_size, m_awsize_o);
        end
        if (m_wvalid_o && m_wready_i)
        begin
          w_hs++;
          if (beat_q.size() == 0)
            flag_error("W handshake with no store pending");
          else
          begin
            beat = beat_q.pop_front();
            check_wbeat(beat[71:8], beat[7:0], m_wdata_o, m_wstrb_o);
          end
        end
        if (ifu_rvalid_o)
        begin
          if (kind != K_FETCH)
            flag_error("fetch data returned for a read that fetch did not own");
          if (!m_rvalid_i)
            flag_error("fetch data returned outside the R beat");
          check_rdata("ifu_rdata_o", mem_word(exp_addr), ifu_rdata_o);
          idle = 1'b1;
        end
        if (lsu_rvalid_o)
        begin
          if (kind == K_TIMER)
          begin
            if (age != 0 || ar_hs != 0)
              flag_error("timer data not returned one cycle after the grant");
            check_rdata("lsu_rdata_o", timer_exp, lsu_rdata_o);
          end
          else
          begin
            if (kind != K_LOAD)
              flag_error("load data returned for a request that is not a load");
            if (!m_rvalid_i)
              flag_error("load data returned outside the R beat");
            check_rdata("lsu_rdata_o", mem_word(exp_addr), lsu_rdata_o);
          end
          idle = 1'b1;
        end
        else if (kind == K_TIMER && age == 0)
          flag_error("timer data missing one cycle after the grant");
        if (lsu_wready_o)
        begin
          if (kind != K_STORE || aw_hs != 1 || w_hs != 1)
            flag_error("store ended without exactly one AW and one W handshake");
          if (!m_bvalid_i)
            flag_error("store completed without a B response");
          idle = 1'b1;
        end
        age++;
      end
      edges++;
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: transactions did not finish within %0d ns", WATCHDOG_NS);
    $display("TB FAILED");
    $finish;
  end

  initial
  begin
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    fork
      run_fetch();
      run_lsu();
    join
    repeat (4) @(negedge clk);
    total = val_errs + other_errs + dut_i.chk_i.fails;
    $display("errors: %0d value, %0d other, %0d assertion",
             val_errs, other_errs, dut_i.chk_i.fails);
    if (total == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// ==== list.f ====
rtl/bus_pkg.sv
rtl/bus_arbiter_fsm.sv
rtl/mtime_counter.sv
rtl/read_return.sv
rtl/store_align.sv
rtl/bus_top.sv
bench/bus_checker.sv
bench/bus_tb.sv

// ==== rtl/bus_arbiter_fsm.sv ====
module bus_arbiter_fsm #(
  parameter logic [bus_pkg::ADDR_W-1:0] CLINT_BASE = 32'h0200_bff8
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [bus_pkg::ADDR_W-1:0] ifu_araddr_i,
  input  logic                       ifu_arvalid_i,
  input  logic [bus_pkg::ADDR_W-1:0] lsu_araddr_i,
  input  logic                       lsu_arvalid_i,
  input  logic [bus_pkg::ADDR_W-1:0] lsu_awaddr_i,
  input  logic                       lsu_awvalid_i,
  input  logic                       m_arready_i,
  input  logic                       m_awready_i,
  input  logic                       m_wready_i,
  input  logic                       m_rvalid_i,
  input  logic                       m_bvalid_i,
  output logic [bus_pkg::ADDR_W-1:0] m_araddr_o,
  output logic                       m_arvalid_o,
  output logic [bus_pkg::ADDR_W-1:0] m_awaddr_o,
  output logic                       m_awvalid_o,
  output logic                       m_wvalid_o,
  output logic [2:0]                 addr_lo_o,
  output bus_pkg::owner_t            rd_owner_o,
  output logic                       lane_hi_o,
  output logic                       timer_sel_o,
  output logic                       timer_rd_o,
  output logic                       word_hi_o,
  output logic                       rd_done_o,
  output logic                       wr_done_o
);
  import bus_pkg::*;

  arb_state_t        state_q;
  owner_t            owner_q;
  logic [ADDR_W-1:0] addr_q;
  logic              aw_done_q; // AW already accepted
  logic              w_done_q;
  logic              lsu_is_timer;
  logic              aw_ok;
  logic              w_ok;

  // only the two mtime words live in the timer
  assign word_hi_o    = (lsu_araddr_i == CLINT_BASE + 32'd4);
  assign lsu_is_timer = (lsu_araddr_i == CLINT_BASE) | word_hi_o;

  assign timer_rd_o = (state_q == IDLE) & !lsu_awvalid_i & lsu_arvalid_i & lsu_is_timer;

  assign aw_ok = aw_done_q | m_awready_i;
  assign w_ok  = w_done_q | m_wready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= IDLE;
      owner_q   <= FETCH;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end
    else
    begin
      case (state_q)
        IDLE:
        begin
          aw_done_q <= 1'b0;
          w_done_q  <= 1'b0;
          if (lsu_awvalid_i) // store first
          begin
            state_q <= LS_WADDR;
          end
          else if (lsu_arvalid_i)
          begin
            owner_q <= LOAD;
            state_q <= lsu_is_timer ? TIMER_RD : LS_RADDR;
          end
          else if (ifu_arvalid_i)
          begin
            owner_q <= FETCH;
            state_q <= IF_ADDR;
          end
        end
        IF_ADDR:  if (m_arready_i) state_q <= IF_DATA;
        IF_DATA:  if (m_rvalid_i) state_q <= IDLE;
        LS_RADDR: if (m_arready_i) state_q <= LS_RDATA;
        LS_RDATA: if (m_rvalid_i) state_q <= IDLE;
        LS_WADDR:
        begin
          if (aw_ok & w_ok)
          begin
            state_q   <= LS_WRESP;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
          end
          else
          begin
            aw_done_q <= aw_ok;
            w_done_q  <= w_ok;
          end
        end
        LS_WRESP: if (m_bvalid_i) state_q <= IDLE;
        default:  state_q <= IDLE; // TIMER_RD lasts one cycle
      endcase
    end
  end

  // address captured on the grant edge only
  always_ff @(posedge clk)
  begin
    if (state_q == IDLE)
    begin
      if (lsu_awvalid_i)
        addr_q <= lsu_awaddr_i;
      else if (lsu_arvalid_i)
        addr_q <= lsu_araddr_i;
      else
        addr_q <= ifu_araddr_i;
    end
  end

  assign m_araddr_o  = addr_q;
  assign m_awaddr_o  = addr_q;
  assign m_arvalid_o = (state_q == IF_ADDR) | (state_q == LS_RADDR);
  assign m_awvalid_o = (state_q == LS_WADDR) & !aw_done_q;
  assign m_wvalid_o  = (state_q == LS_WADDR) & !w_done_q;

  assign addr_lo_o   = addr_q[2:0];
  assign lane_hi_o   = addr_q[2];
  assign rd_owner_o  = owner_q;
  assign timer_sel_o = (state_q == TIMER_RD);
  assign rd_done_o   = ((state_q == IF_DATA) | (state_q == LS_RDATA)) & m_rvalid_i;
  assign wr_done_o   = (state_q == LS_WRESP) & m_bvalid_i;

endmodule

// ==== rtl/bus_pkg.sv ====
package bus_pkg;

  parameter int ADDR_W = 32;
  parameter int DATA_W = 32;

  typedef enum logic [2:0] {
    IDLE,
    IF_ADDR,
    IF_DATA,
    LS_RADDR,
    LS_RDATA,
    LS_WADDR,
    LS_WRESP,
    TIMER_RD
  } arb_state_t;

  // who gets the current read
  typedef enum logic {
    FETCH,
    LOAD
  } owner_t;

  typedef enum logic [2:0] {
    SIZE_B = 3'd0,
    SIZE_H = 3'd1,
    SIZE_W = 3'd2
  } axi_size_t;

endpackage

// ==== rtl/bus_top.sv ====
module bus_top #(
  parameter logic [bus_pkg::ADDR_W-1:0] CLINT_BASE = 32'h0200_bff8
) (
  input  logic                       clk,
  input  logic                       rst,
  // fetch
  input  logic [bus_pkg::ADDR_W-1:0] ifu_araddr_i,
  input  logic                       ifu_arvalid_i,
  output logic [bus_pkg::DATA_W-1:0] ifu_rdata_o,
  output logic                       ifu_rvalid_o,
  // load / store
  input  logic [bus_pkg::ADDR_W-1:0] lsu_araddr_i,
  input  logic                       lsu_arvalid_i,
  input  logic [7:0]                 lsu_rstrb_i,
  output logic [bus_pkg::DATA_W-1:0] lsu_rdata_o,
  output logic                       lsu_rvalid_o,
  input  logic [bus_pkg::ADDR_W-1:0] lsu_awaddr_i,
  input  logic                       lsu_awvalid_i,
  input  logic [bus_pkg::DATA_W-1:0] lsu_wdata_i,
  input  logic [7:0]                 lsu_wstrb_i,
  output logic                       lsu_wready_o,
  // AXI master
  output logic [bus_pkg::ADDR_W-1:0] m_araddr_o,
  output bus_pkg::axi_size_t         m_arsize_o,
  output logic                       m_arvalid_o,
  input  logic                       m_arready_i,
  input  logic [63:0]                m_rdata_i,
  input  logic                       m_rvalid_i,
  output logic [bus_pkg::ADDR_W-1:0] m_awaddr_o,
  output bus_pkg::axi_size_t         m_awsize_o,
  output logic                       m_awvalid_o,
  input  logic                       m_awready_i,
  output logic [63:0]                m_wdata_o,
  output logic [7:0]                 m_wstrb_o,
  output logic                       m_wvalid_o,
  input  logic                       m_wready_i,
  input  logic                       m_bvalid_i
);
  import bus_pkg::*;

  logic [2:0]        addr_lo;
  owner_t            rd_owner;
  logic              lane_hi;
  logic              timer_sel;
  logic              timer_rd;
  logic              word_hi;
  logic              rd_done;
  logic              wr_done;
  logic [DATA_W-1:0] timer_rdata;
  logic              timer_rvalid;

  bus_arbiter_fsm #(
    .CLINT_BASE (CLINT_BASE)
  ) fsm_i (
    .clk           (clk),
    .rst           (rst),
    .ifu_araddr_i  (ifu_araddr_i),
    .ifu_arvalid_i (ifu_arvalid_i),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .lsu_awvalid_i (lsu_awvalid_i),
    .m_arready_i   (m_arready_i),
    .m_awready_i   (m_awready_i),
    .m_wready_i    (m_wready_i),
    .m_rvalid_i    (m_rvalid_i),
    .m_bvalid_i    (m_bvalid_i),
    .m_araddr_o    (m_araddr_o),
    .m_arvalid_o   (m_arvalid_o),
    .m_awaddr_o    (m_awaddr_o),
    .m_awvalid_o   (m_awvalid_o),
    .m_wvalid_o    (m_wvalid_o),
    .addr_lo_o     (addr_lo),
    .rd_owner_o    (rd_owner),
    .lane_hi_o     (lane_hi),
    .timer_sel_o   (timer_sel),
    .timer_rd_o    (timer_rd),
    .word_hi_o     (word_hi),
    .rd_done_o     (rd_done),
    .wr_done_o     (wr_done)
  );

  mtime_counter mtime_i (
    .clk        (clk),
    .rst        (rst),
    .timer_rd_i (timer_rd),
    .word_hi_i  (word_hi),
    .rdata_o    (timer_rdata),
    .rvalid_o   (timer_rvalid)
  );

  // qualified rvalid from the data states
  read_return rret_i (
    .m_rdata_i      (m_rdata_i),
    .m_rvalid_i     (rd_done),
    .rd_owner_i     (rd_owner),
    .lane_hi_i      (lane_hi),
    .timer_sel_i    (timer_sel),
    .timer_rdata_i  (timer_rdata),
    .timer_rvalid_i (timer_rvalid),
    .ifu_rdata_o    (ifu_rdata_o),
    .ifu_rvalid_o   (ifu_rvalid_o),
    .lsu_rdata_o    (lsu_rdata_o),
    .lsu_rvalid_o   (lsu_rvalid_o)
  );

  store_align align_i (
    .addr_lo_i   (addr_lo),
    .lsu_wdata_i (lsu_wdata_i),
    .lsu_wstrb_i (lsu_wstrb_i),
    .lsu_rstrb_i (lsu_rstrb_i),
    .rd_owner_i  (rd_owner),
    .m_wdata_o   (m_wdata_o),
    .m_wstrb_o   (m_wstrb_o),
    .m_awsize_o  (m_awsize_o),
    .m_arsize_o  (m_arsize_o)
  );

  assign lsu_wready_o = wr_done;

endmodule

// ==== rtl/mtime_counter.sv ====
module mtime_counter (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       timer_rd_i,
  input  logic                       word_hi_i,
  output logic [bus_pkg::DATA_W-1:0] rdata_o,
  output logic                       rvalid_o
);
  import bus_pkg::*;

  logic [63:0] mtime_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q  <= 64'd0;
      rvalid_o <= 1'b0;
    end
    else
    begin
      mtime_q  <= mtime_q + 64'd1;
      rvalid_o <= timer_rd_i; // one cycle pulse
    end
  end

  // pre-increment value of the read edge
  always_ff @(posedge clk)
  begin
    if (timer_rd_i)
      rdata_o <= word_hi_i ? mtime_q[63:32] : mtime_q[DATA_W-1:0];
  end

endmodule

// ==== rtl/read_return.sv ====
module read_return (
  input  logic [63:0]                m_rdata_i,
  input  logic                       m_rvalid_i,
  input  bus_pkg::owner_t            rd_owner_i,
  input  logic                       lane_hi_i,
  input  logic                       timer_sel_i,
  input  logic [bus_pkg::DATA_W-1:0] timer_rdata_i,
  input  logic                       timer_rvalid_i,
  output logic [bus_pkg::DATA_W-1:0] ifu_rdata_o,
  output logic                       ifu_rvalid_o,
  output logic [bus_pkg::DATA_W-1:0] lsu_rdata_o,
  output logic                       lsu_rvalid_o
);
  import bus_pkg::*;

  logic [DATA_W-1:0] lane;
  logic              bus_to_ifu;
  logic              bus_to_lsu;

  // upper word sits in the high lane
  assign lane = lane_hi_i ? m_rdata_i[63:32] : m_rdata_i[31:0];

  assign bus_to_ifu = m_rvalid_i & !timer_sel_i & (rd_owner_i == FETCH);
  assign bus_to_lsu = m_rvalid_i & !timer_sel_i & (rd_owner_i == LOAD);

  assign ifu_rdata_o  = lane;
  assign ifu_rvalid_o = bus_to_ifu;

  always_comb
  begin
    if (timer_sel_i)
    begin
      lsu_rdata_o  = timer_rdata_i;
      lsu_rvalid_o = timer_rvalid_i;
    end
    else
    begin
      lsu_rdata_o  = lane;
      lsu_rvalid_o = bus_to_lsu;
    end
  end

endmodule

// ==== rtl/store_align.sv ====
module store_align (
  input  logic [2:0]                 addr_lo_i,
  input  logic [bus_pkg::DATA_W-1:0] lsu_wdata_i,
  input  logic [7:0]                 lsu_wstrb_i,
  input  logic [7:0]                 lsu_rstrb_i,
  input  bus_pkg::owner_t            rd_owner_i,
  output logic [63:0]                m_wdata_o,
  output logic [7:0]                 m_wstrb_o,
  output bus_pkg::axi_size_t         m_awsize_o,
  output bus_pkg::axi_size_t         m_arsize_o
);
  import bus_pkg::*;

  logic [DATA_W-1:0] wdata_sh;
  logic [3:0]        strb_sh;

  function automatic axi_size_t size_of(input logic [7:0] strb);
    axi_size_t sz;
    case (strb)
      8'h01:   sz = SIZE_B;
      8'h03:   sz = SIZE_H;
      default: sz = SIZE_W;
    endcase
    return sz;
  endfunction

  // byte offset within the word
  assign wdata_sh = lsu_wdata_i << {addr_lo_i[1:0], 3'b000};
  assign strb_sh  = lsu_wstrb_i[3:0] << addr_lo_i[1:0];

  assign m_wdata_o = {wdata_sh, wdata_sh}; // same word in both lanes
  assign m_wstrb_o = addr_lo_i[2] ? {strb_sh, 4'b0000} : {4'b0000, strb_sh};

  assign m_awsize_o = size_of(lsu_wstrb_i);
  assign m_arsize_o = (rd_owner_i == FETCH) ? SIZE_W : size_of(lsu_rstrb_i);

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module bus_tb -f list.f -o bus_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

# keep running past assertion errors so the testbench reaches its verdict
out=$(./obj_dir/bus_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
